//--- include/accel_macros.svh
`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// line geometry
////////////////////////////////////////////////////////////////////////////

// lanes per memory line
`define N_LANES         16
`define I_WIDTH         8
`define F_WIDTH         8

// one DRAM beat and how many of them make a line
`define DRAM_WIDTH      32
`define WORDS_PER_LINE  4

// 16 lines in each RAM
`define LINE_ADDR_WIDTH 4

////////////////////////////////////////////////////////////////////////////
// run control and accumulation
////////////////////////////////////////////////////////////////////////////

`define MAX_RUN         15
`define RUN_WIDTH       $clog2(`MAX_RUN + 1)

// result wraps modulo 2^24
`define ACC_WIDTH       24

`endif

//--- rtl/mem_pkg.sv
`default_nettype none

`include "accel_macros.svh"

package mem_pkg;

    // one beat from DRAM
    typedef logic [`DRAM_WIDTH-1:0] dram_word_t;

    typedef logic [`LINE_ADDR_WIDTH-1:0] line_addr_t;

    // word position inside a line
    typedef logic [$clog2(`WORDS_PER_LINE)-1:0] word_idx_t;

    typedef logic [`RUN_WIDTH-1:0] run_len_t;

endpackage

`default_nettype wire

//--- rtl/accel_pkg.sv
`default_nettype none

`include "accel_macros.svh"

package accel_pkg;

    ////////////////////////////////////////////////////////////////////////
    // lane operands
    ////////////////////////////////////////////////////////////////////////

    typedef logic signed [`I_WIDTH-1:0] feature_t;
    typedef logic signed [`F_WIDTH-1:0] weight_t;

    // full-precision lane product
    typedef logic signed [`I_WIDTH+`F_WIDTH-1:0] product_t;

    // sum of all lane products, grows by log2 of the lane count
    typedef logic signed [`I_WIDTH+`F_WIDTH+$clog2(`N_LANES)-1:0] line_sum_t;

    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

    ////////////////////////////////////////////////////////////////////////
    // memory lines, lane 0 in the low byte
    ////////////////////////////////////////////////////////////////////////

    typedef feature_t [`N_LANES-1:0] feature_line_t;
    typedef weight_t  [`N_LANES-1:0] weight_line_t;

endpackage

`default_nettype wire

//--- rtl/mac_ctrl_if.sv
`default_nettype none

// pipeline control from the sequencer into the datapath
interface mac_ctrl_if;

    // RAM outputs valid this cycle
    logic weight_ld;
    // first line of a run, restart the accumulator
    logic acc_clear;
    // adder-tree register holds a line sum
    logic sum_valid;
    // final line of the run
    logic last;

    modport seq (
        output weight_ld,
        output acc_clear,
        output sum_valid,
        output last
    );

    modport dp (
        input  weight_ld,
        input  acc_clear,
        input  sum_valid,
        input  last
    );

endinterface

`default_nettype wire

//--- rtl/line_packer.sv
`default_nettype none

`include "accel_macros.svh"

module line_packer
    import mem_pkg::*;
#(
    parameter type line_t = logic [`DRAM_WIDTH*`WORDS_PER_LINE-1:0]
) (
    input  wire logic       clk_i,
    input  wire logic       rd_weight_rst,
    input  wire logic       word_valid_i,
    input  wire dram_word_t word_i,
    input  wire line_addr_t line_addr_i,
    output logic            wr_en_o,
    output line_addr_t      wr_addr_o,
    output line_t           line_o
);

    localparam int LINE_BITS = $bits(line_t);

    logic [LINE_BITS-1:0] shift_q;
    word_idx_t            word_cnt_q;
    logic                 wr_en_q;
    line_addr_t           wr_addr_q;
    logic                 last_word;

    assign last_word = word_valid_i && (word_cnt_q == word_idx_t'(`WORDS_PER_LINE - 1));

    // new words enter at the top, so word 0 ends up in the low bits
    always_ff @(posedge clk_i) begin
        if (word_valid_i) begin
            shift_q <= {word_i, shift_q[LINE_BITS-1:`DRAM_WIDTH]};
        end
    end

    // counter wraps back to 0 after the last word of a line
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            word_cnt_q <= '0;
            wr_en_q    <= 1'b0;
        end else begin
            wr_en_q <= last_word;
            if (word_valid_i) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    // destination captured with the closing word
    always_ff @(posedge clk_i) begin
        if (last_word) begin
            wr_addr_q <= line_addr_i;
        end
    end

    assign wr_en_o   = wr_en_q;
    assign wr_addr_o = wr_addr_q;
    assign line_o    = line_t'(shift_q);

endmodule

`default_nettype wire

//--- rtl/line_ram.sv
`default_nettype none

`include "accel_macros.svh"

module line_ram
    import mem_pkg::*;
#(
    parameter type line_t = logic [`DRAM_WIDTH*`WORDS_PER_LINE-1:0]
) (
    input  wire logic       clk_i,
    input  wire logic       wr_en_i,
    input  wire line_addr_t wr_addr_i,
    input  wire line_t      wr_line_i,
    input  wire logic       rd_en_i,
    input  wire line_addr_t rd_addr_i,
    output line_t           rd_line_o
);

    localparam int DEPTH = 1 << `LINE_ADDR_WIDTH;

    line_t mem [DEPTH];
    line_t rd_line_q;

    // write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_line_i;
        end
    end

    // read port, output holds between reads
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_line_q <= mem[rd_addr_i];
        end
    end

    assign rd_line_o = rd_line_q;

endmodule

`default_nettype wire

//--- rtl/conv_sequencer.sv
`default_nettype none

module conv_sequencer
    import mem_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rd_weight_rst,
    input  wire logic     start_i,
    input  wire run_len_t run_len_i,
    output logic          rd_en_o,
    output line_addr_t    rd_addr_o,
    output logic          busy_o,
    mac_ctrl_if.seq       ctrl
);

    logic       busy_q;
    logic       rd_active_q;
    line_addr_t rd_addr_q;
    run_len_t   run_len_q;
    logic       start_ok;
    logic       rd_last;

    // tag pipeline: stage 0 = RAM out, stage 1 = operands, stage 2 = line sum
    logic [2:0] tag_valid_q;
    logic [2:0] tag_last_q;
    logic [2:0] tag_first_q;
    // last line has been accumulated
    logic       tail_q;

    assign start_ok = start_i && !busy_q;
    assign rd_last  = (rd_addr_q == line_addr_t'(run_len_q - 1'b1));

    ////////////////////////////////////////////////////////////////////////////
    // run control and read addressing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (start_ok) begin
            run_len_q <= run_len_i;
        end
    end

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            busy_q      <= 1'b0;
            rd_active_q <= 1'b0;
            rd_addr_q   <= '0;
        end else if (start_ok) begin
            busy_q      <= 1'b1;
            rd_active_q <= 1'b1;
            rd_addr_q   <= '0;
        end else begin
            if (rd_active_q) begin
                rd_addr_q <= rd_addr_q + 1'b1;
                if (rd_last) begin
                    rd_active_q <= 1'b0;
                end
            end
            // drops on the edge that raises done
            if (tail_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tags follow each read down the datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            tag_valid_q <= '0;
            tag_last_q  <= '0;
            tag_first_q <= '0;
            tail_q      <= 1'b0;
        end else begin
            tag_valid_q <= {tag_valid_q[1:0], rd_active_q};
            tag_last_q  <= {tag_last_q[1:0], rd_active_q && rd_last};
            tag_first_q <= {tag_first_q[1:0], rd_active_q && (rd_addr_q == '0)};
            tail_q      <= tag_valid_q[2] && tag_last_q[2];
        end
    end

    assign rd_en_o   = rd_active_q;
    assign rd_addr_o = rd_addr_q;
    assign busy_o    = busy_q;

    assign ctrl.weight_ld = tag_valid_q[0];
    assign ctrl.sum_valid = tag_valid_q[2];
    assign ctrl.last      = tag_last_q[2];
    assign ctrl.acc_clear = tag_valid_q[2] && tag_first_q[2];

endmodule

`default_nettype wire

//--- rtl/dot_product_unit.sv
`default_nettype none

`include "accel_macros.svh"

module dot_product_unit
    import accel_pkg::*;
(
    input  wire logic          clk_i,
    input  wire logic          rd_weight_rst,
    input  wire feature_line_t feature_line_i,
    input  wire weight_line_t  weight_line_i,
    mac_ctrl_if.dp             ctrl,
    output logic               done_o,
    output acc_t               result_o
);

    localparam int N = `N_LANES;

    feature_line_t feature_q;
    weight_line_t  weight_q;
    product_t      prod [N];
    // heap-ordered adder tree, node 0 is the root
    line_sum_t     tree [2*N-1];
    line_sum_t     sum_q;
    acc_t          acc_q;
    logic          acc_last_q;
    logic          done_q;
    acc_t          result_q;

    ////////////////////////////////////////////////////////////////////////////
    // operand registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            weight_q <= '0;
        end else if (ctrl.weight_ld) begin
            weight_q <= weight_line_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl.weight_ld) begin
            feature_q <= feature_line_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lane multipliers and adder tree
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < N; i++) begin
            prod[i]         = feature_q[i] * weight_q[i];
            tree[N - 1 + i] = line_sum_t'(prod[i]);
        end
        for (int n = N - 2; n >= 0; n--) begin
            tree[n] = tree[2*n + 1] + tree[2*n + 2];
        end
    end

    always_ff @(posedge clk_i) begin
        sum_q <= tree[0];
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulator and result
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            acc_q      <= '0;
            acc_last_q <= 1'b0;
            done_q     <= 1'b0;
            result_q   <= '0;
        end else begin
            if (ctrl.sum_valid) begin
                // first line of a run replaces the old total
                acc_q <= ctrl.acc_clear ? acc_t'(sum_q) : acc_q + acc_t'(sum_q);
            end
            acc_last_q <= ctrl.sum_valid && ctrl.last;
            done_q     <= acc_last_q;
            if (acc_last_q) begin
                result_q <= acc_q;
            end
        end
    end

    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

`default_nettype wire

//--- rtl/accel_top.sv
`default_nettype none

module accel_top
    import mem_pkg::*;
    import accel_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rd_weight_rst,
    input  wire dram_word_t mem_data_i,
    input  wire logic       mem_valid_i,
    input  wire logic       mem_sel_i,
    input  wire line_addr_t wr_line_i,
    input  wire logic       start_i,
    input  wire run_len_t   run_len_i,
    output logic            busy_o,
    output logic            done_o,
    output acc_t            result_o
);

    logic          feat_valid;
    logic          wgt_valid;

    logic          feat_wr_en;
    line_addr_t    feat_wr_addr;
    feature_line_t feat_wr_line;
    logic          wgt_wr_en;
    line_addr_t    wgt_wr_addr;
    weight_line_t  wgt_wr_line;

    logic          rd_en;
    line_addr_t    rd_addr;
    feature_line_t feat_rd_line;
    weight_line_t  wgt_rd_line;

    mac_ctrl_if mac_ctrl ();

    // sel 0 feeds the feature side, sel 1 the weight side
    assign feat_valid = mem_valid_i && !mem_sel_i;
    assign wgt_valid  = mem_valid_i && mem_sel_i;

    ////////////////////////////////////////////////////////////////////////////
    // load path
    ////////////////////////////////////////////////////////////////////////////

    line_packer #(.line_t(feature_line_t)) feature_packer (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .word_valid_i  (feat_valid),
        .word_i        (mem_data_i),
        .line_addr_i   (wr_line_i),
        .wr_en_o       (feat_wr_en),
        .wr_addr_o     (feat_wr_addr),
        .line_o        (feat_wr_line)
    );

    line_packer #(.line_t(weight_line_t)) weight_packer (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .word_valid_i  (wgt_valid),
        .word_i        (mem_data_i),
        .line_addr_i   (wr_line_i),
        .wr_en_o       (wgt_wr_en),
        .wr_addr_o     (wgt_wr_addr),
        .line_o        (wgt_wr_line)
    );

    line_ram #(.line_t(feature_line_t)) feature_mem (
        .clk_i     (clk_i),
        .wr_en_i   (feat_wr_en),
        .wr_addr_i (feat_wr_addr),
        .wr_line_i (feat_wr_line),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_line_o (feat_rd_line)
    );

    line_ram #(.line_t(weight_line_t)) weight_mem (
        .clk_i     (clk_i),
        .wr_en_i   (wgt_wr_en),
        .wr_addr_i (wgt_wr_addr),
        .wr_line_i (wgt_wr_line),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_line_o (wgt_rd_line)
    );

    ////////////////////////////////////////////////////////////////////////////
    // run control and datapath
    ////////////////////////////////////////////////////////////////////////////

    // both RAMs share one read address
    conv_sequencer u_conv_sequencer (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .start_i       (start_i),
        .run_len_i     (run_len_i),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .busy_o        (busy_o),
        .ctrl          (mac_ctrl.seq)
    );

    dot_product_unit u_dot_product_unit (
        .clk_i          (clk_i),
        .rd_weight_rst  (rd_weight_rst),
        .feature_line_i (feat_rd_line),
        .weight_line_i  (wgt_rd_line),
        .ctrl           (mac_ctrl.dp),
        .done_o         (done_o),
        .result_o       (result_o)
    );

endmodule

`default_nettype wire

//--- test/tb_accel_top.sv
`default_nettype none

module tb_accel_top
    import mem_pkg::*;
    import accel_pkg::*;
();

    localparam int          CLK_PERIOD        = 100;
    localparam int          DRIVE_DELAY       = 10;
    localparam int          RESET_CYCLES      = 10;
    localparam int          LATENCY           = 4;
    localparam int          MAX_RECORDS       = 64;
    localparam int          CYCLES_PER_RECORD = 30;
    localparam int          WATCHDOG_MARGIN   = 100;
    localparam logic [31:0] SEED              = 32'h662a_f4c8;

    logic       clk_i;
    logic       rd_weight_rst;
    dram_word_t mem_data_i;
    logic       mem_valid_i;
    logic       mem_sel_i;
    line_addr_t wr_line_i;
    logic       start_i;
    run_len_t   run_len_i;
    logic       busy_o;
    logic       done_o;
    acc_t       result_o;

    // records from the pattern file
    byte         rec_kind  [MAX_RECORDS];
    logic [31:0] rec_arg0  [MAX_RECORDS];
    logic [31:0] rec_arg1  [MAX_RECORDS];
    dram_word_t  rec_words [MAX_RECORDS][4];
    int          num_records;

    accel_top UUT (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .mem_data_i    (mem_data_i),
        .mem_valid_i   (mem_valid_i),
        .mem_sel_i     (mem_sel_i),
        .wr_line_i     (wr_line_i),
        .start_i       (start_i),
        .run_len_i     (run_len_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .result_o      (result_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        fail_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    endtask

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    task automatic check_cleared();
        assert (busy_o === 1'b0) else report_mismatch("busy_o", 32'(busy_o), 32'h0);
        assert (done_o === 1'b0) else report_mismatch("done_o", 32'(done_o), 32'h0);
        assert (result_o === '0) else report_mismatch("result_o", {8'h0, result_o}, 32'h0);
    endtask

    task automatic read_patterns();
        int          fd;
        int          fields;
        int          count;
        string       line;
        byte         kind;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] w [4];
        fd = $fopen("test/accel_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open test/accel_patterns.txt");
        end
        count = 0;
        while ($fgets(line, fd) > 0) begin
            kind = line.getc(0);
            // comment and blank lines carry no record
            if (kind == "L" || kind == "R") begin
                if (count == MAX_RECORDS) begin
                    fail_run("pattern file holds too many records");
                end
                if (kind == "L") begin
                    fields = $sscanf(line, "L %h %h %h %h %h %h", a0, a1,
                                     w[0], w[1], w[2], w[3]);
                end else begin
                    fields = $sscanf(line, "R %h %h", a0, a1);
                end
                if (fields != ((kind == "L") ? 6 : 2)) begin
                    fail_run($sformatf("malformed line in pattern file: %s", line));
                end
                rec_kind[count] = kind;
                rec_arg0[count] = a0;
                rec_arg1[count] = a1;
                for (int j = 0; j < 4; j++) begin
                    rec_words[count][j] = (kind == "L") ? w[j] : '0;
                end
                count++;
            end
        end
        $fclose(fd);
        if (count == 0) begin
            fail_run("pattern file holds no records");
        end
        num_records = count;
    endtask

    // four words with 0 to 3 idle cycles in front of each
    task automatic load_line(input int idx);
        int idle;
        mem_sel_i = rec_arg0[idx][0];
        wr_line_i = line_addr_t'(rec_arg1[idx]);
        for (int j = 0; j < 4; j++) begin
            idle        = $urandom % 4;
            mem_valid_i = 1'b0;
            repeat (idle) next_cycle();
            mem_valid_i = 1'b1;
            mem_data_i  = rec_words[idx][j];
            next_cycle();
        end
        mem_valid_i = 1'b0;
    endtask

    task automatic run_check(input int idx);
        int          n;
        int          cycles;
        logic [23:0] expected;
        logic [23:0] held;
        n         = int'(rec_arg0[idx]);
        expected  = rec_arg1[idx][23:0];
        held      = result_o;
        start_i   = 1'b1;
        run_len_i = run_len_t'(n);
        next_cycle();
        start_i = 1'b0;
        // cycles counts edges after the one that took start_i
        cycles = 0;
        while (done_o !== 1'b1) begin
            if (cycles > n + LATENCY + 4) begin
                fail_run($sformatf("done_o did not pulse within %0d cycles of start", cycles));
            end
            assert (busy_o === 1'b1) else report_mismatch("busy_o", 32'(busy_o), 32'h1);
            assert (result_o === held) else
                report_mismatch("result_o", {8'h0, result_o}, {8'h0, held});
            // a start while busy must not restart the run
            start_i   = (cycles == 2);
            run_len_i = (cycles == 2) ? run_len_t'(1) : run_len_t'(n);
            next_cycle();
            cycles++;
        end
        start_i = 1'b0;
        assert (cycles == n + LATENCY) else report_mismatch("done_o latency", cycles, n + LATENCY);
        assert (busy_o === 1'b0) else report_mismatch("busy_o", 32'(busy_o), 32'h0);
        assert (result_o === expected) else
            report_mismatch("result_o", {8'h0, result_o}, {8'h0, expected});
        // single pulse and the result holds afterwards
        repeat (3) begin
            next_cycle();
            assert (done_o === 1'b0) else report_mismatch("done_o", 32'(done_o), 32'h0);
            assert (busy_o === 1'b0) else report_mismatch("busy_o", 32'(busy_o), 32'h0);
            assert (result_o === expected) else
                report_mismatch("result_o", {8'h0, result_o}, {8'h0, expected});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk_i         = 1'b0;
        rd_weight_rst = 1'b1;
        mem_data_i    = '0;
        mem_valid_i   = 1'b0;
        mem_sel_i     = 1'b0;
        wr_line_i     = '0;
        start_i       = 1'b0;
        run_len_i     = '0;
        void'($urandom(SEED));
        read_patterns();
        repeat (RESET_CYCLES) begin
            next_cycle();
            check_cleared();
        end
        rd_weight_rst = 1'b0;
        next_cycle();
        check_cleared();
        for (int i = 0; i < num_records; i++) begin
            if (rec_kind[i] == "L") begin
                load_line(i);
            end else begin
                run_check(i);
            end
        end
        $display("Simulation passed");
        $finish;
    end

    // limit scales with the number of records
    initial begin
        wait (num_records > 0);
        repeat (num_records * CYCLES_PER_RECORD + WATCHDOG_MARGIN) @(posedge clk_i);
        fail_run("watchdog expired before all pattern records were processed");
    end

endmodule

`default_nettype wire

//--- test/accel_patterns.txt
# L <sel: 0 feature, 1 weight> <line> <word0> <word1> <word2> <word3>, all hex
# R <run length> <expected 24-bit result>, all hex
L 0 0 01010101 02020202 03030303 04040404
L 1 0 02020202 01010101 FFFFFFFF 03030303
L 0 1 00FF0110 FEFEFEFE 10101010 00000000
L 1 1 7F020304 F0F0F0F0 02020202 7F7F7F7F
L 0 2 80808080 7F7F7F7F 01010101 02020202
L 1 2 7F7F7F7F 80808080 FEFEFEFE 05050505
L 0 3 03030303 03030303 03030303 03030303
L 1 3 02020202 02020202 02020202 02020202
L 0 4 04040404 04040404 04040404 04040404
L 1 4 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
L 0 5 05050505 05050505 05050505 05050505
L 1 5 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A
L 0 6 06060606 06060606 06060606 06060606
L 1 6 F6F6F6F6 F6F6F6F6 F6F6F6F6 F6F6F6F6
L 0 7 07070707 07070707 07070707 07070707
L 1 7 01010101 01010101 01010101 01010101
L 0 8 08080808 08080808 08080808 08080808
L 1 8 80808080 80808080 80808080 80808080
L 0 9 09090909 09090909 09090909 09090909
L 1 9 7F7F7F7F 7F7F7F7F 7F7F7F7F 7F7F7F7F
L 0 A 0A0A0A0A 0A0A0A0A 0A0A0A0A 0A0A0A0A
L 1 A 00000000 00000000 00000000 00000000
L 0 B 0B0B0B0B 0B0B0B0B 0B0B0B0B 0B0B0B0B
L 1 B 05050505 05050505 05050505 05050505
L 0 C 0C0C0C0C 0C0C0C0C 0C0C0C0C 0C0C0C0C
L 1 C FDFDFDFD FDFDFDFD FDFDFDFD FDFDFDFD
L 0 D 0D0D0D0D 0D0D0D0D 0D0D0D0D 0D0D0D0D
L 1 D 02020202 02020202 02020202 02020202
L 0 E 0E0E0E0E 0E0E0E0E 0E0E0E0E 0E0E0E0E
L 1 E 81818181 81818181 81818181 81818181
R 1 000034
R 2 000175
R F FDA0A5
R 3 FE0595
R 6 FE08D5
R 9 FDC585
R A FE0CF5
L 0 0 10101010 10101010 10101010 10101010
R 1 000140
L 1 E 01010101 01010101 01010101 01010101
R F FE11B1

//--- filelist.f
+incdir+include
rtl/mem_pkg.sv
rtl/accel_pkg.sv
rtl/mac_ctrl_if.sv
rtl/line_packer.sv
rtl/line_ram.sv
rtl/conv_sequencer.sv
rtl/dot_product_unit.sv
rtl/accel_top.sv
test/tb_accel_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_accel_top
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test target: FAILED"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
